// File: design/des_pkg.sv
`default_nettype none

package des_pkg;

    localparam int DES_ROUNDS = 16;

    // DES numbering throughout, bit 1 is the MSB
    typedef logic [1:32] des_half_t;
    typedef logic [1:48] des_subkey_t;

    typedef struct packed {
        des_half_t l;  // Upper 32 bits of the block
        des_half_t r;
    } des_halves_t;

    // Ports and permutations see one word, the rounds see two halves
    typedef union packed {
        logic [1:64] word;
        des_halves_t halves;
    } des_block_u;

    typedef des_subkey_t [1:DES_ROUNDS] des_subkeys_t;  // Indexed by round number

    // Payload passed from stage to stage
    typedef struct packed {
        logic       valid;
        logic       decrypt;  // Selects subkeys in reverse order
        des_block_u blk;
    } des_stage_t;

    // Table selectors for des_permute
    localparam int PERM_IP  = 0;
    localparam int PERM_FP  = 1;
    localparam int PERM_E   = 2;
    localparam int PERM_P   = 3;
    localparam int PERM_PC1 = 4;
    localparam int PERM_PC2 = 5;

    // Entries name the source bit, counted from 1 at the MSB
    localparam int IP_TABLE [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int FP_TABLE [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25
    };

    localparam int E_TABLE [48] = '{   // 32 to 48 bit expansion
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam int P_TABLE [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    localparam int PC1_TABLE [56] = '{  // Drops the eight parity bits
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
    };

    localparam int PC2_TABLE [48] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    // Left rotation of C and D before each round
    localparam int SHIFT_TABLE [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    // Eight boxes of four rows by sixteen columns, row major
    localparam logic [3:0] SBOX_TABLE [8][64] = '{
        '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,   // S1
           0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
           4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
          15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
        '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,   // S2
           3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
           0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
          13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
        '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,   // S3
          13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
          13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
           1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
        '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,   // S4
          13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
          10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
           3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
        '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,   // S5
          14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
           4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
          11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
        '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,   // S6
          10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
           9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
           4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
        '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,   // S7
          13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
           1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
           6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
        '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,   // S8
           1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
           7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
           2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
    };

    // Gathers din bits in table order
    // Narrow inputs and results sit left aligned in the 64 bit word
    function automatic logic [1:64] des_permute(input logic [1:64] din, input int sel);
        logic [1:64] dout;
        dout = '0;
        case (sel)
            PERM_IP:  for (int i = 0; i < 64; i++)
                          dout[i + 1] = din[IP_TABLE[i]];
            PERM_FP:  for (int i = 0; i < 64; i++)
                          dout[i + 1] = din[FP_TABLE[i]];
            PERM_E:   for (int i = 0; i < 48; i++)
                          dout[i + 1] = din[E_TABLE[i]];
            PERM_P:   for (int i = 0; i < 32; i++)
                          dout[i + 1] = din[P_TABLE[i]];
            PERM_PC1: for (int i = 0; i < 56; i++)
                          dout[i + 1] = din[PC1_TABLE[i]];
            PERM_PC2: for (int i = 0; i < 48; i++)
                          dout[i + 1] = din[PC2_TABLE[i]];
            default:  dout = din;  // Unknown selector passes through
        endcase
        return dout;
    endfunction

    // Row from the two outer bits and column from the middle four
    function automatic logic [5:0] des_sbox_index(input logic [1:6] grp);
        return {grp[1], grp[6], grp[2:5]};
    endfunction

endpackage

`default_nettype wire

// File: design/des_sbox.sv
`timescale 1ns/100ps
`default_nettype none

module des_sbox import des_pkg::*; (
    input  logic [1:48] data_in,   // Expanded R xor subkey
    output des_half_t   data_out   // Substituted word ahead of P
);

    // One lookup per 6 bit group
    // Group g feeds box g+1 and fills output nibble g
    for (genvar g = 0; g < 8; g++) begin : g_box
        logic [1:6] grp;  // Six input bits of this box
        logic [5:0] idx;  // Row and column folded into a table index

        assign grp = data_in[g * 6 + 1 +: 6];
        assign idx = des_sbox_index(grp);

        // Table rows hold sixteen columns so idx addresses row*16 + col
        assign data_out[g * 4 + 1 +: 4] = SBOX_TABLE[g][idx];
    end

endmodule

`default_nettype wire

// File: design/des_round.sv
`timescale 1ns/100ps
`default_nettype none

module des_round import des_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,     // Low holds the stage
    input  logic        flush,      // Drops the stage contents
    input  des_stage_t  stage_in,
    input  des_subkey_t key_fwd,    // Subkey of this round
    input  des_subkey_t key_rev,    // Subkey of the mirrored round
    output des_stage_t  stage_out
);

    des_subkey_t round_key;   // Subkey picked by the block's mode
    logic [1:64] e_out;       // Expansion result, 48 bits left aligned
    logic [1:48] sbox_in;
    des_half_t   sbox_out;
    logic [1:64] p_out;       // P result, 32 bits left aligned

    logic        valid_q;
    logic        decrypt_q;
    des_half_t   s_q;         // Registered S-box output
    des_half_t   l_q;
    des_half_t   r_q;

    // Decryption walks the subkeys backwards
    assign round_key = stage_in.decrypt ? key_rev : key_fwd;

    assign e_out   = des_permute({stage_in.blk.halves.r, 32'h0}, PERM_E);
    assign sbox_in = e_out[1:48] ^ round_key;

    des_sbox u_sbox (
        .data_in  (sbox_in),
        .data_out (sbox_out)
    );

    // Flush wins over enable
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            valid_q <= 1'b0;
        end else if (enable) begin
            valid_q <= stage_in.valid;
        end
    end

    // Only real blocks are captured
    always_ff @(posedge clk) begin
        if (enable && stage_in.valid) begin
            s_q       <= sbox_out;
            l_q       <= stage_in.blk.halves.l;
            r_q       <= stage_in.blk.halves.r;
            decrypt_q <= stage_in.decrypt;
        end
    end

    // P and the xor into L sit after the register
    assign p_out = des_permute({s_q, 32'h0}, PERM_P);

    always_comb begin
        stage_out.valid         = valid_q;
        stage_out.decrypt       = decrypt_q;
        stage_out.blk.halves.l  = r_q;               // Old R moves left
        stage_out.blk.halves.r  = l_q ^ p_out[1:32];  // New R
    end

    // A flushed stage never shows a block on the next cycle
    assert property (@(posedge clk) flush |=> !stage_out.valid)
        else $error("des_round valid survived a flush");

endmodule

`default_nettype wire

// File: design/des_key_schedule.sv
`timescale 1ns/100ps
`default_nettype none

module des_key_schedule import des_pkg::*; (
    input  logic         clk,
    input  logic         key_load,  // Capture strobe
    input  logic [63:0]  key,       // Parity bits included, PC-1 drops them
    output des_subkeys_t subkeys    // Round 1 to 16, valid the cycle after key_load
);

    logic [1:64] key_q;                 // Held key in DES bit order
    logic [1:64] pc1_out;               // 56 bit PC-1 result, left aligned
    logic [1:28] c_rot [0:DES_ROUNDS];  // C half after each cumulative rotation
    logic [1:28] d_rot [0:DES_ROUNDS];  // D half likewise

    // Key stays put until the next strobe
    always_ff @(posedge clk) begin
        if (key_load) begin
            key_q <= key;
        end
    end

    // PC-1 splits the key into C and D
    assign pc1_out  = des_permute(key_q, PERM_PC1);
    assign c_rot[0] = pc1_out[1:28];
    assign d_rot[0] = pc1_out[29:56];

    // Each round rotates the previous round's halves
    // so round r sees the sum of the first r shifts
    for (genvar r = 1; r <= DES_ROUNDS; r++) begin : g_subkey
        logic [1:64] pc2_out;  // 48 bit PC-2 result, left aligned

        if (SHIFT_TABLE[r - 1] == 1) begin : g_rot1
            // Rounds 1, 2, 9 and 16
            assign c_rot[r] = {c_rot[r - 1][2:28], c_rot[r - 1][1]};
            assign d_rot[r] = {d_rot[r - 1][2:28], d_rot[r - 1][1]};
        end else begin : g_rot2
            assign c_rot[r] = {c_rot[r - 1][3:28], c_rot[r - 1][1:2]};
            assign d_rot[r] = {d_rot[r - 1][3:28], d_rot[r - 1][1:2]};
        end

        // PC-2 picks 48 of the 56 rotated bits
        assign pc2_out    = des_permute({c_rot[r], d_rot[r], 8'h00}, PERM_PC2);
        assign subkeys[r] = pc2_out[1:48];
    end

endmodule

`default_nettype wire

// File: design/des_core.sv
`timescale 1ns/100ps
`default_nettype none

module des_core import des_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        key_load,   // Loads key, only with the pipeline empty
    input  logic [63:0] key,
    input  logic        in_valid,
    input  logic        decrypt,    // Mode of this block
    input  logic [63:0] data_in,
    input  logic        enable,     // Low freezes every stage
    input  logic        flush,      // Clears every valid bit
    output logic        out_valid,
    output logic [63:0] data_out
);

    des_subkeys_t subkeys;
    des_stage_t   in_stage_q;                   // After the initial permutation
    des_stage_t   round_stage [0:DES_ROUNDS];   // Entry 0 feeds round 1
    des_block_u   swapped;                      // Round 16 output with halves swapped
    logic [1:64]  fp_out;
    logic         any_valid;                    // Some block is in flight

    des_key_schedule u_key_schedule (
        .clk      (clk),
        .key_load (key_load),
        .key      (key),
        .subkeys  (subkeys)
    );

    // Input stage with IP
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            in_stage_q.valid <= 1'b0;
        end else if (enable) begin
            in_stage_q.valid <= in_valid;
        end
        if (enable && in_valid) begin
            in_stage_q.decrypt  <= decrypt;
            in_stage_q.blk.word <= des_permute(data_in, PERM_IP);
        end
    end

    assign round_stage[0] = in_stage_q;

    // Sixteen rounds, each one register deep
    for (genvar i = 1; i <= DES_ROUNDS; i++) begin : g_round
        des_round u_round (
            .clk       (clk),
            .rst_n     (rst_n),
            .enable    (enable),
            .flush     (flush),
            .stage_in  (round_stage[i - 1]),
            .key_fwd   (subkeys[i]),
            .key_rev   (subkeys[DES_ROUNDS + 1 - i]),
            .stage_out (round_stage[i])
        );
    end

    // Undo the last round's swap
    always_comb begin
        swapped.halves.l = round_stage[DES_ROUNDS].blk.halves.r;
        swapped.halves.r = round_stage[DES_ROUNDS].blk.halves.l;
    end

    assign fp_out = des_permute(swapped.word, PERM_FP);

    // Output stage
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            out_valid <= 1'b0;
        end else if (enable) begin
            out_valid <= round_stage[DES_ROUNDS].valid;
        end
        if (enable && round_stage[DES_ROUNDS].valid) begin
            data_out <= fp_out;
        end
    end

    // Any valid bit from input stage to output
    always_comb begin
        any_valid = out_valid;
        for (int i = 0; i <= DES_ROUNDS; i++) begin
            any_valid = any_valid | round_stage[i].valid;
        end
    end

    // Subkeys are shared by all rounds so the key must not move under a block
    assert property (@(posedge clk) disable iff (!rst_n) !(key_load && any_valid))
        else $error("key_load while blocks are in flight");

endmodule

`default_nettype wire

// File: tb/des_ref_model.svh
`ifndef DES_REF_MODEL_SVH
`define DES_REF_MODEL_SVH

// Software DES built straight from the standard's tables
// Vectors use DES numbering with bit 1 as the MSB

// f(R, K) of one Feistel round
function automatic logic [1:32] feistel_mix(input logic [1:32] r, input logic [1:48] k);
    logic [1:48] x;
    logic [1:32] s;
    logic [1:32] p;
    logic [1:6]  grp;
    logic [1:0]  row;
    logic [3:0]  col;
    for (int i = 0; i < 48; i++) begin
        x[i + 1] = r[E_TABLE[i]];  // Expansion
    end
    x = x ^ k;
    for (int b = 0; b < 8; b++) begin
        grp = x[b * 6 + 1 +: 6];
        row = {grp[1], grp[6]};    // Outer bits
        col = grp[2:5];            // Inner bits
        s[b * 4 + 1 +: 4] = SBOX_TABLE[b][{row, col}];
    end
    for (int i = 0; i < 32; i++) begin
        p[i + 1] = s[P_TABLE[i]];
    end
    return p;
endfunction

// Whole cipher, key schedule included, one block
function automatic logic [63:0] cipher_block(input logic [63:0] key, input logic [63:0] din,
                                             input logic dec);
    logic [1:64] k;
    logic [1:56] cd;
    logic [1:28] c;
    logic [1:28] d;
    logic [1:48] ks [1:16];   // Subkeys by round
    logic [1:64] blk;
    logic [1:64] ip;
    logic [1:32] l;
    logic [1:32] r;
    logic [1:32] t;
    logic [1:64] pre;
    logic [1:64] res;
    k = key;
    for (int i = 0; i < 56; i++) begin
        cd[i + 1] = k[PC1_TABLE[i]];
    end
    c = cd[1:28];
    d = cd[29:56];
    for (int n = 0; n < 16; n++) begin
        // Rotate one bit at a time, once or twice
        for (int s = 0; s < SHIFT_TABLE[n]; s++) begin
            c = {c[2:28], c[1]};
            d = {d[2:28], d[1]};
        end
        cd = {c, d};
        for (int i = 0; i < 48; i++) begin
            ks[n + 1][i + 1] = cd[PC2_TABLE[i]];
        end
    end
    blk = din;
    for (int i = 0; i < 64; i++) begin
        ip[i + 1] = blk[IP_TABLE[i]];
    end
    l = ip[1:32];
    r = ip[33:64];
    for (int n = 1; n <= 16; n++) begin
        t = r;
        r = l ^ feistel_mix(r, dec ? ks[17 - n] : ks[n]);  // Decrypt runs keys backwards
        l = t;
    end
    pre = {r, l};  // Final swap
    for (int i = 0; i < 64; i++) begin
        res[i + 1] = pre[FP_TABLE[i]];
    end
    return res;
endfunction

`endif

// File: tb/des_tb.sv
`timescale 1ns/100ps
`default_nettype none

module des_tb import des_pkg::*; ();

    localparam int BLOCKS         = 300;
    localparam int TIMEOUT_CYCLES = 4 * BLOCKS * 4 + 200;

    localparam logic [63:0] KAT_KEY    = 64'h133457799BBCDFF1;
    localparam logic [63:0] KAT_PLAIN  = 64'h0123456789ABCDEF;
    localparam logic [63:0] KAT_CIPHER = 64'h85E813540F0AB405;

    // One expected result in flight
    typedef struct packed {
        logic        feed_back;  // Result goes back in for decryption
        logic [63:0] plain;      // Plaintext behind this block
        logic [63:0] exp_val;
    } sb_entry_t;

    logic        clk;
    logic        rst_n;
    logic        key_load;
    logic [63:0] key;
    logic        in_valid;
    logic        decrypt;
    logic [63:0] data_in;
    logic        enable;
    logic        flush;
    logic        out_valid;
    logic [63:0] data_out;

    sb_entry_t   sb_q [$];   // Expected outputs in order
    logic [63:0] ct_q [$];   // Ciphertexts waiting to return
    logic [63:0] pt_q [$];   // Their plaintexts
    logic [31:0] lfsr_state;
    logic [63:0] cur_key;    // Key the model works with
    int          cycle_cnt;

    `include "des_ref_model.svh"

    des_core u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_load  (key_load),
        .key       (key),
        .in_valid  (in_valid),
        .decrypt   (decrypt),
        .data_in   (data_in),
        .enable    (enable),
        .flush     (flush),
        .out_valid (out_valid),
        .data_out  (data_out)
    );

    always #50 clk = ~clk;  // 100 ns period

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Inputs change 1 ns after the edge and hold through the next one
    task automatic drive_cycle(input logic v, input logic dec, input logic [63:0] d,
                               input logic en, input sb_entry_t e);
        in_valid = v;
        decrypt  = dec;
        data_in  = d;
        enable   = en;
        if (v && en) begin
            sb_q.push_back(e);  // Taken at the coming edge
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_random(input logic en);
        logic [63:0] pt;
        logic [63:0] m;
        sb_entry_t   e;
        pt = rand_bits(64);
        m  = rand_bits(1);
        e  = '{1'b0, pt, cipher_block(cur_key, pt, m[0])};
        drive_cycle(1'b1, m[0], pt, en, e);
    endtask

    task automatic load_key(input logic [63:0] k);
        key_load = 1'b1;
        key      = k;
        in_valid = 1'b0;
        enable   = 1'b1;
        cur_key  = k;
        @(posedge clk);
        #1;
        key_load = 1'b0;
    endtask

    // Idle with enable high until every expected block is out
    task automatic wait_drain();
        while (sb_q.size() != 0) begin
            drive_cycle(1'b0, 1'b0, '0, 1'b1, '0);
        end
    endtask

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, results stopped arriving", cycle_cnt);
            $display("Test failed");
            $fatal(1);
        end
    end

    // Scoreboard consumes one output block at each enabled edge
    always @(posedge clk) begin
        sb_entry_t e;
        if (flush) begin
            sb_q.delete();  // Everything in flight is gone
        end else if (rst_n && enable && out_valid) begin
            if (sb_q.size() == 0) begin
                $display("out_valid at %0t ns with no block expected", $time);
                $display("Test failed");
                $fatal(1);
            end else begin
                e = sb_q.pop_front();
                check_value("data_out", data_out, e.exp_val);
                if (e.feed_back) begin
                    ct_q.push_back(data_out);
                    pt_q.push_back(e.plain);
                end
            end
        end
    end

    initial begin
        logic [63:0] r;
        logic [63:0] ct;
        sb_entry_t   e;
        int          start;
        logic        seen;
        int          enc_sent;
        int          dec_sent;
        clk        = 1'b0;
        rst_n      = 1'b0;
        key_load   = 1'b0;
        key        = '0;
        in_valid   = 1'b0;
        decrypt    = 1'b0;
        data_in    = '0;
        enable     = 1'b0;
        flush      = 1'b0;
        cycle_cnt  = 0;
        cur_key    = '0;
        lfsr_state = 32'h4e5b;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Known answer both ways
        load_key(KAT_KEY);
        check_value("model ciphertext", cipher_block(KAT_KEY, KAT_PLAIN, 1'b0), KAT_CIPHER);
        e = '{1'b0, KAT_PLAIN, KAT_CIPHER};
        drive_cycle(1'b1, 1'b0, KAT_PLAIN, 1'b1, e);
        e = '{1'b0, KAT_CIPHER, KAT_PLAIN};
        drive_cycle(1'b1, 1'b1, KAT_CIPHER, 1'b1, e);
        wait_drain();

        // Full rate stream with the first result taken 18 edges after its input
        seen  = 1'b0;
        start = 0;
        for (int i = 0; i < BLOCKS; i++) begin
            send_random(1'b1);
            if (i == 0) begin
                start = cycle_cnt;
            end
            if (!seen && out_valid) begin
                seen = 1'b1;
                // Sampled at the coming edge
                check_value("first out_valid latency", 64'(cycle_cnt + 1 - start), 64'd18);
            end
        end
        wait_drain();

        // Enable low about 30% of cycles
        for (int i = 0; i < BLOCKS; i++) begin
            r = rand_bits(4);
            send_random(r[3:0] >= 4'd5);
        end
        wait_drain();

        // Ciphertexts come back as decrypts mixed with new encrypts
        enc_sent = 0;
        dec_sent = 0;
        while (dec_sent < BLOCKS) begin
            r = rand_bits(1);
            if (ct_q.size() > 0 && (enc_sent == BLOCKS || r[0])) begin
                ct = ct_q.pop_front();
                e  = '{1'b0, ct, pt_q.pop_front()};  // Plaintext must return
                drive_cycle(1'b1, 1'b1, ct, 1'b1, e);
                dec_sent++;
            end else if (enc_sent < BLOCKS) begin
                r = rand_bits(64);
                e = '{1'b1, r, cipher_block(cur_key, r, 1'b0)};
                drive_cycle(1'b1, 1'b0, r, 1'b1, e);
                enc_sent++;
            end else begin
                drive_cycle(1'b0, 1'b0, '0, 1'b1, '0);  // Waiting for results
            end
        end
        wait_drain();

        // Flush with every stage up to the output holding a block and enable low
        for (int i = 0; i < DES_ROUNDS + 2; i++) begin
            send_random(1'b1);
        end
        flush = 1'b1;
        drive_cycle(1'b0, 1'b0, '0, 1'b0, '0);
        flush = 1'b0;
        for (int i = 0; i < 30; i++) begin
            drive_cycle(1'b0, 1'b0, '0, 1'b1, '0);
            check_value("out_valid after flush", {63'b0, out_valid}, 64'd0);
        end
        for (int i = 0; i < 20; i++) begin
            send_random(1'b1);
        end
        wait_drain();

        // New key on an empty pipeline
        r = rand_bits(64);
        load_key(r);
        for (int i = 0; i < BLOCKS; i++) begin
            send_random(1'b1);
        end
        wait_drain();

        if (sb_q.size() == 0 && ct_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("blocks left unchecked at the end of the run");
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: des.f
+incdir+tb
design/des_pkg.sv
design/des_sbox.sv
design/des_round.sv
design/des_key_schedule.sv
design/des_core.sv
tb/des_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module des_tb -f des.f \
    --Mdir obj_dir -o des_sim

# The simulator's own exit status is not used, the log decides
./obj_dir/des_sim 2>&1 | tee sim.log

if grep -q "^Test completed successfully$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
